/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

	// Address and data geometry
	localparam int ADDR_W   = 64;
	localparam int WORD_W   = 64;
	localparam int LINE_W   = 128;
	localparam int NUM_WAYS = 4;

	// Address split is tag [63:10], index [9:4], byte offset [3:0]
	localparam int OFFSET_W = 4;
	localparam int INDEX_W  = 6;
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [LINE_W-1:0]   line_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [NUM_WAYS-1:0] way_mask_t; // One-hot or zero

	// Controller states
	typedef enum logic {
		ST_LOOKUP,  // Idle or sampling a request
		ST_RESPOND  // Ready is high for this one cycle
	} ctrl_state_e;

	// Tag field of an address
	function automatic tag_t addr_tag(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	// Set index field of an address
	function automatic index_t addr_index(addr_t a);
		return a[OFFSET_W +: INDEX_W];
	endfunction

endpackage

`default_nettype wire

/* design/way_access_if.sv */
`timescale 1ns/100ps
`default_nettype none

// One access to the tag and data arrays, issued by the controller
interface way_access_if import dcache_pkg::*; ();

	way_mask_t                 way_en; // Nonzero only in the cycle of an access
	logic                      write;  // Fill when high, read otherwise
	index_t                    index;
	line_t                     wdata;
	line_t [NUM_WAYS-1:0]      rdata;  // Read data one cycle after a read

	modport ctrl (
		output way_en, write, index, wdata,
		input  rdata
	);

	modport tags (
		input way_en, write, index
	);

	modport data (
		input  way_en, write, index, wdata,
		output rdata
	);

endinterface

`default_nettype wire

/* design/data_sram.sv */
`timescale 1ns/100ps
`default_nettype none

// Single-port synchronous SRAM holding one way of the cache
module data_sram import dcache_pkg::*; (
	input  wire         clk,
	input  wire         en,
	input  wire         we,
	input  wire index_t index,
	input  wire line_t  wdata,
	output line_t       rdata
);

	localparam int DEPTH = 2 ** INDEX_W;

	line_t mem [DEPTH];

	// Read data is registered, so it shows up the cycle after the enable
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata; // Output keeps its last read value
			end else begin
				rdata <= mem[index];
			end
		end
	end

endmodule

`default_nettype wire

/* design/dcache_tag_array.sv */
`timescale 1ns/100ps
`default_nettype none

// Tags and valid bits of all four ways, with hit detection and invalidation
module dcache_tag_array import dcache_pkg::*; #(
	parameter addr_t CACHEABLE_LIMIT = 64'h8fffffff
) (
	input  wire            clk,
	input  wire            rst,
	input  wire addr_t     addr,
	input  wire            inv_valid,
	input  wire addr_t     inv_addr,
	output way_mask_t      way_hit,
	way_access_if.tags     acc
);

	localparam int NUM_SETS = 2 ** INDEX_W;

	tag_t                tags       [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];

	index_t    req_index;
	tag_t      req_tag;
	index_t    inv_index;
	tag_t      inv_tag;
	logic      cacheable;
	way_mask_t fill;
	way_mask_t inv_match;

	assign req_index = addr_index(addr);
	assign req_tag   = addr_tag(addr);
	assign inv_index = addr_index(inv_addr);
	assign inv_tag   = addr_tag(inv_addr);
	assign cacheable = (addr <= CACHEABLE_LIMIT);
	assign fill      = acc.way_en & {NUM_WAYS{acc.write}};

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = valid_bits[w][req_index] && (tags[w][req_index] == req_tag);
		end
	end

	// Compare against the tag the way will hold after this edge, so that
	// an invalidation of the line being filled still takes effect
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill[w] && cacheable && (acc.index == inv_index)) begin
				inv_match[w] = (req_tag == inv_tag);
			end else begin
				inv_match[w] = (tags[w][inv_index] == inv_tag);
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill[w] && cacheable) begin
				tags[w][acc.index] <= req_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill[w]) begin
					// An uncacheable fill still overwrites the victim's data
					valid_bits[w][acc.index] <= cacheable;
				end
				if (inv_valid && inv_match[w]) begin
					valid_bits[w][inv_index] <= 1'b0; // Later assignment, so it wins
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/dcache_data_array.sv */
`timescale 1ns/100ps
`default_nettype none

// Line storage of the four ways
module dcache_data_array import dcache_pkg::*; (
	input  wire        clk,
	way_access_if.data acc
);

	line_t [NUM_WAYS-1:0] sram_rdata;

	// All ways share the address and write data, only the enables differ
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		data_sram u_sram (
			.clk   (clk),
			.en    (acc.way_en[w]),
			.we    (acc.write),
			.index (acc.index),
			.wdata (acc.wdata),
			.rdata (sram_rdata[w])
		);
	end

	assign acc.rdata = sram_rdata;

endmodule

`default_nettype wire

/* design/dcache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

// Request sequencing, victim selection and response word select
module dcache_ctrl import dcache_pkg::*; (
	input  wire            clk,
	input  wire            rst,
	input  wire            valid,
	input  wire addr_t     addr,
	input  wire way_mask_t way_hit,
	input  wire line_t     mem_line,
	output logic           ready,
	output word_t          dout,
	output addr_t          mem_addr,
	way_access_if.ctrl     acc
);

	ctrl_state_e state;
	way_mask_t   victim;   // One-hot rotating replacement pointer
	way_mask_t   hit_q;    // Hit vector of the request being answered
	line_t       line_q;   // Line fetched from memory at lookup
	line_t       line_sel;
	logic        lookup;
	logic        miss;

	assign lookup = (state == ST_LOOKUP) && valid;
	assign miss   = (way_hit == '0);

	// Read the hit way, or fill the victim with the line from memory
	assign acc.way_en = lookup ? (miss ? victim : way_hit) : '0;
	assign acc.write  = lookup && miss;
	assign acc.index  = addr_index(addr);
	assign acc.wdata  = mem_line;

	assign mem_addr = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= ST_LOOKUP;
			victim <= way_mask_t'(1);
			hit_q  <= '0;
		end else begin
			case (state)
				ST_LOOKUP: begin
					if (valid) begin
						state <= ST_RESPOND;
						hit_q <= way_hit;
						if (miss) begin
							victim <= {victim[NUM_WAYS-2:0], victim[NUM_WAYS-1]};
						end
					end
				end
				ST_RESPOND: begin
					state <= ST_LOOKUP; // Always one response cycle
				end
				default: begin
					state <= ST_LOOKUP;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (lookup) begin
			line_q <= mem_line;
		end
	end

	// A miss answers from the line buffer, a hit from its way's SRAM
	always_comb begin
		line_sel = line_q;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hit_q[w]) begin
				line_sel = acc.rdata[w];
			end
		end
	end

	assign dout  = addr[OFFSET_W-1] ? line_sel[LINE_W-1 -: WORD_W] : line_sel[WORD_W-1:0];
	assign ready = (state == ST_RESPOND);

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

// Read-only four-way data cache
module dcache_top import dcache_pkg::*; #(
	parameter addr_t CACHEABLE_LIMIT = 64'h8fffffff // Highest address that is kept
) (
	input  wire        clk,
	input  wire        rst,
	input  wire        valid,
	input  wire addr_t addr,
	input  wire        inv_valid,
	input  wire addr_t inv_addr,
	input  wire line_t mem_line,
	output logic       ready,
	output word_t      dout,
	output addr_t      mem_addr
);

	way_mask_t way_hit;

	way_access_if acc ();

	dcache_ctrl u_ctrl (
		.clk      (clk),
		.rst      (rst),
		.valid    (valid),
		.addr     (addr),
		.way_hit  (way_hit),
		.mem_line (mem_line),
		.ready    (ready),
		.dout     (dout),
		.mem_addr (mem_addr),
		.acc      (acc.ctrl)
	);

	dcache_tag_array #(
		.CACHEABLE_LIMIT (CACHEABLE_LIMIT)
	) u_tags (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.inv_valid (inv_valid),
		.inv_addr  (inv_addr),
		.way_hit   (way_hit),
		.acc       (acc.tags)
	);

	dcache_data_array u_data (
		.clk (clk),
		.acc (acc.data)
	);

endmodule

`default_nettype wire

/* tests/tb_dcache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

	localparam addr_t LIMIT          = 64'h8fffffff;
	localparam int    RESET_CYCLES   = 8;
	localparam int    NUM_ACCESSES   = 110; // Reads and invalidations over all tests
	localparam int    TIMEOUT_CYCLES = RESET_CYCLES + 4 * NUM_ACCESSES + 200;
	localparam int    NUM_SETS       = 2 ** INDEX_W;

	logic  clk;
	logic  rst;
	logic  valid;
	addr_t addr;
	logic  inv_valid;
	addr_t inv_addr;
	line_t mem_line;
	logic  ready;
	word_t dout;
	addr_t mem_addr;

	line_t       mem_model [addr_t]; // Lines written by the tests, keyed by line address
	int          mem_rev;            // Bumped on every memory change
	logic [15:0] lfsr_state;
	int          cycle_count;
	int          num_errors;

	// Reference cache state
	tag_t  ref_tag   [NUM_WAYS][NUM_SETS];
	logic  ref_valid [NUM_WAYS][NUM_SETS];
	line_t ref_data  [NUM_WAYS][NUM_SETS];
	int    ref_victim;

	dcache_top #(
		.CACHEABLE_LIMIT (LIMIT)
	) dut (
		.clk       (clk),
		.rst       (rst),
		.valid     (valid),
		.addr      (addr),
		.inv_valid (inv_valid),
		.inv_addr  (inv_addr),
		.mem_line  (mem_line),
		.ready     (ready),
		.dout      (dout),
		.mem_addr  (mem_addr)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	// Backing memory answers in the same cycle
	always begin
		mem_line = mem_read(mem_addr);
		@(mem_addr or mem_rev);
	end

	task automatic abort_run(input string msg);
		num_errors++;
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, expected, actual));
		end
	endtask

	// Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[62:0], lfsr_bit()};
		end
		return r;
	endfunction

	function automatic addr_t make_addr(tag_t t, index_t s, logic upper);
		return {t, s, upper, 3'b000};
	endfunction

	function automatic line_t mem_read(addr_t a);
		addr_t la;
		la = {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
		if (mem_model.exists(la)) begin
			return mem_model[la];
		end
		return {~la, la ^ 64'h0123_4567_89ab_cdef}; // Untouched lines follow their address
	endfunction

	task automatic write_line(input addr_t a);
		addr_t la;
		word_t hi;
		word_t lo;
		la = {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
		lo = rand_bits(WORD_W);
		hi = rand_bits(WORD_W);
		mem_model[la] = {hi, lo};
		mem_rev++;
	endtask

	function automatic void clear_model();
		for (int w = 0; w < NUM_WAYS; w++) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				ref_valid[w][s] = 1'b0;
				ref_tag[w][s]   = '0;
			end
		end
		ref_victim = 0;
	endfunction

	// Way holding the address, or -1
	function automatic int find_way(addr_t a);
		index_t s;
		s = a[OFFSET_W +: INDEX_W];
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_valid[w][s] && (ref_tag[w][s] == a[ADDR_W-1 -: TAG_W])) begin
				return w;
			end
		end
		return -1;
	endfunction

	// Line the cache should return, with the fill and pointer step of a miss
	function automatic line_t predict_read(addr_t a);
		index_t s;
		int     w;
		line_t  l;
		s = a[OFFSET_W +: INDEX_W];
		w = find_way(a);
		if (w >= 0) begin
			return ref_data[w][s];
		end
		l = mem_read(a);
		ref_data[ref_victim][s]  = l;
		ref_valid[ref_victim][s] = (a <= LIMIT);
		if (a <= LIMIT) begin
			ref_tag[ref_victim][s] = a[ADDR_W-1 -: TAG_W];
		end
		ref_victim = (ref_victim + 1) % NUM_WAYS;
		return l;
	endfunction

	function automatic void apply_invalidate(addr_t a);
		index_t s;
		s = a[OFFSET_W +: INDEX_W];
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_tag[w][s] == a[ADDR_W-1 -: TAG_W]) ref_valid[w][s] = 1'b0;
		end
	endfunction

	// One read, checked against the reference model
	task automatic read_access(input string name, input addr_t a, output word_t got);
		line_t exp_line;
		word_t exp_word;
		addr_t exp_addr;
		int    waited;
		exp_line = predict_read(a);
		exp_word = a[OFFSET_W-1] ? exp_line[LINE_W-1 -: WORD_W] : exp_line[WORD_W-1:0];
		exp_addr = a & ~addr_t'(4'hf); // Line address seen by the memory
		@(posedge clk);
		valid <= 1'b1;
		addr  <= a;
		waited = 0;
		@(negedge clk);
		while (ready !== 1'b1) begin
			waited++;
			if (waited > 4) abort_run($sformatf("No ready for the read of %h in %s", a, name));
			@(negedge clk);
		end
		check_bit({name, " ready latency"}, 1'b1, waited == 1); // Lookup edge sits in between
		got = dout;
		check_word(name, exp_word, got);
		check_addr({name, " mem_addr"}, exp_addr, mem_addr);
	endtask

	task automatic send_invalidate(input addr_t a);
		@(posedge clk);
		valid     <= 1'b0;
		inv_valid <= 1'b1;
		inv_addr  <= a;
		@(posedge clk);
		inv_valid <= 1'b0;
		apply_invalidate(a);
	endtask

	task automatic reset_then_miss();
		addr_t a;
		line_t l;
		word_t got;
		a = make_addr(tag_t'(1), index_t'(5), 1'b0);
		write_line(a);
		l = mem_read(a);
		read_access("reset_miss lower", a, got);
		check_word("reset_miss lower word", l[WORD_W-1:0], got);
		read_access("reset_miss upper", a | 64'h8, got);
		check_word("reset_miss upper word", l[LINE_W-1 -: WORD_W], got);
	endtask

	task automatic hit_keeps_old();
		addr_t a;
		line_t old_line;
		word_t got;
		a = make_addr(tag_t'(1), index_t'(5), 1'b0);
		old_line = mem_read(a); // Cached by the previous test
		write_line(a);
		read_access("hit_old lower", a, got);
		check_word("hit_old lower word", old_line[WORD_W-1:0], got);
		read_access("hit_old upper", a | 64'h8, got);
		check_word("hit_old upper word", old_line[LINE_W-1 -: WORD_W], got);
	endtask

	task automatic invalidate_refetch();
		addr_t a;
		line_t old_line;
		line_t new_line;
		word_t got;
		a = make_addr(tag_t'(3), index_t'(9), 1'b1);
		old_line = mem_read(a);
		read_access("invalidate first", a, got);
		write_line(a);
		new_line = mem_read(a);
		send_invalidate(make_addr(tag_t'(77), index_t'(9), 1'b0)); // Other tag, same set
		read_access("invalidate other tag", a, got);
		check_word("invalidate other tag word", old_line[LINE_W-1 -: WORD_W], got);
		send_invalidate(a);
		read_access("invalidate refetch", a, got);
		check_word("invalidate refetch word", new_line[LINE_W-1 -: WORD_W], got);
	endtask

	task automatic uncacheable_reads();
		addr_t a;
		line_t l;
		word_t got;
		a = 64'h0000_0001_2345_6788; // Above the limit
		for (int i = 0; i < 3; i++) begin
			write_line(a);
			l = mem_read(a);
			read_access("uncacheable", a, got);
			check_word("uncacheable word", l[LINE_W-1 -: WORD_W], got);
		end
	endtask

	task automatic round_robin_evict();
		addr_t a        [5];
		line_t old_line [5];
		line_t new_line [5];
		int    evicted;
		word_t got;
		for (int i = 0; i < 5; i++) begin
			a[i] = make_addr(tag_t'(20 + i), index_t'(12), 1'b0);
			old_line[i] = mem_read(a[i]);
			read_access("round_robin fill", a[i], got);
		end
		for (int i = 0; i < 5; i++) begin
			write_line(a[i]);
			new_line[i] = mem_read(a[i]);
		end
		evicted = 0;
		for (int i = 0; i < 5; i++) begin
			if (find_way(a[i]) < 0) begin
				evicted = i;
			end
		end
		// Survivors first, so that the refetch cannot evict one of them
		for (int i = 0; i < 5; i++) begin
			if (i != evicted) begin
				read_access("round_robin kept", a[i], got);
				check_word("round_robin kept word", old_line[i][WORD_W-1:0], got);
			end
		end
		read_access("round_robin evicted", a[evicted], got);
		check_word("round_robin evicted word", new_line[evicted][WORD_W-1:0], got);
	endtask

	task automatic back_to_back_traffic();
		logic [63:0] sel;
		addr_t       a;
		word_t       got;
		for (int i = 0; i < 40; i++) begin
			sel = rand_bits(8);
			a = make_addr(tag_t'(40 + sel[2:0]), index_t'(32 + sel[3]), sel[5]);
			if (sel[7:6] == 2'b00) begin
				write_line(a);
			end else if (sel[7:6] == 2'b01) begin
				send_invalidate(a);
			end
			read_access($sformatf("traffic %0d", i), a, got);
		end
	endtask

	initial begin
		rst         = 1'b1;
		valid       = 1'b0;
		addr        = '0;
		inv_valid   = 1'b0;
		inv_addr    = '0;
		mem_rev     = 0;
		lfsr_state  = 16'd42816;
		cycle_count = 0;
		num_errors  = 0;
		clear_model();
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_bit("reset ready", 1'b0, ready);
		reset_then_miss();
		hit_keeps_old();
		invalidate_refetch();
		uncacheable_reads();
		round_robin_evict();
		back_to_back_traffic();
		@(posedge clk);
		valid <= 1'b0;
		if (num_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
design/dcache_pkg.sv
design/way_access_if.sv
design/data_sram.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tests/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - design/dcache_pkg.sv
      - design/way_access_if.sv
      - design/data_sram.sv
      - design/dcache_tag_array.sv
      - design/dcache_data_array.sv
      - design/dcache_ctrl.sv
      - design/dcache_top.sv
  - target: test
    files:
      - tests/tb_dcache.sv
